//--- common/mem_pkg.sv
package mem_pkg;

    // ####################################################################
    // Instruction fields
    // ####################################################################

    // Opcode bits [6:2] of the instruction word.
    typedef enum logic [4:0] {
        OPC_LOAD  = 5'b00000,
        OPC_STORE = 5'b01000,
        OPC_OTHER = 5'b01100
    } opcode_e;

    typedef enum logic [2:0] {
        FNC_SB = 3'b000,
        FNC_SH = 3'b001,
        FNC_SW = 3'b010
    } store_funct_e;

    typedef enum logic [2:0] {
        FNC_LB  = 3'b000,
        FNC_LH  = 3'b001,
        FNC_LW  = 3'b010,
        FNC_LBU = 3'b100,
        FNC_LHU = 3'b101
    } load_funct_e;

    // ####################################################################
    // Request and write-select bundles
    // ####################################################################

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] rs2;      // Store data, not yet aligned.
        logic        we;
        opcode_e     opcode;
        logic [2:0]  funct3;
        logic        pc30;     // Fetch PC bit 30, set while running from boot space.
    } mem_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  dmem_wea;
        logic [3:0]  imem_wea;
    } lane_wr_t;

    typedef struct packed {
        logic uart_we;
        logic counter_reset;
        logic leds_we;
        logic tx_we;
        logic tx_duty_we;
    } io_wr_t;

    // ####################################################################
    // Address map
    // ####################################################################

    // The LED register shares its word with the transmitter window,
    // which covers selects 6 and 7.
    typedef enum logic [2:0] {
        IO_UART    = 3'd1,
        IO_COUNTER = 3'd3,
        IO_LEDS    = 3'd6,
        IO_TX      = 3'd7
    } io_sel_e;

    localparam int DMEM_BIT    = 28;
    localparam int IMEM_BIT    = 29;
    localparam int IO_BIT      = 31;
    localparam int IO_SEL_HI   = 5;
    localparam int IO_SEL_LO   = 3;
    localparam int TX_DUTY_BIT = 2;

endpackage

//--- src/store_sel.sv
`timescale 1ns/1ns

module store_sel (
    input  mem_pkg::mem_req_t req,
    output mem_pkg::lane_wr_t lanes,
    output mem_pkg::io_wr_t   io_wr
);
    import mem_pkg::*;

    logic [3:0]  mask;
    logic [31:0] data;
    logic        io_hit;
    io_sel_e     io_sel;

    // ####################################################################
    // Lane alignment
    // ####################################################################

    always_comb begin
        mask = 4'b0000;
        data = req.rs2;
        if (req.we && req.opcode == OPC_STORE) begin
            case (store_funct_e'(req.funct3))
                FNC_SB: begin
                    mask = 4'b0001 << req.addr[1:0];
                    data = {24'b0, req.rs2[7:0]} << {req.addr[1:0], 3'b000};
                end
                FNC_SH: begin
                    mask = req.addr[1] ? 4'b1100 : 4'b0011;
                    data = req.addr[1] ? {req.rs2[15:0], 16'b0} : {16'b0, req.rs2[15:0]};
                end
                FNC_SW: begin
                    mask = 4'b1111;
                end
                default: begin
                    mask = 4'b0000;   // Unused funct3 codes write nothing.
                end
            endcase
        end
    end

    // ####################################################################
    // Target decode
    // ####################################################################

    assign io_hit = req.addr[IO_BIT];
    assign io_sel = io_sel_e'(req.addr[IO_SEL_HI:IO_SEL_LO]);

    always_comb begin
        lanes.data     = data;
        lanes.dmem_wea = req.addr[DMEM_BIT] ? mask : 4'b0000;
        // Instruction memory is writable only from boot code.
        lanes.imem_wea = (req.addr[IMEM_BIT] && req.pc30) ? mask : 4'b0000;
    end

    always_comb begin
        io_wr.uart_we       = io_hit && io_sel == IO_UART && mask[0];
        io_wr.counter_reset = io_hit && io_sel == IO_COUNTER && (|mask);
        io_wr.leds_we       = io_hit && io_sel == IO_LEDS && mask[0];
        io_wr.tx_we         = io_hit && (io_sel inside {IO_LEDS, IO_TX}) && (|mask);
        io_wr.tx_duty_we    = io_wr.tx_we && req.addr[TX_DUTY_BIT];
    end

endmodule

//--- src/load_align.sv
`timescale 1ns/1ns

module load_align (
    input                     clk,
    input                     rst_n,
    input  mem_pkg::mem_req_t req,
    input  [31:0]             dmem_rdata,
    input  [31:0]             io_rdata,
    output logic [31:0]       ld_data,
    output logic              ld_valid
);
    import mem_pkg::*;

    logic [2:0]  funct3_q;
    logic [1:0]  offset_q;
    logic        io_q;
    logic [31:0] word;
    logic [31:0] shifted;

    // The load strobe becomes the valid pulse one cycle on.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_valid <= 1'b0;
        end else begin
            ld_valid <= req.opcode == OPC_LOAD;
        end
    end

    always_ff @(posedge clk) begin
        funct3_q <= req.funct3;
        offset_q <= req.addr[1:0];
        io_q     <= req.addr[IO_BIT];
    end

    assign word    = io_q ? io_rdata : dmem_rdata;
    assign shifted = word >> {offset_q, 3'b000};   // Addressed byte or half to bit 0.

    always_comb begin
        if (io_q) begin
            ld_data = word;
        end else begin
            case (load_funct_e'(funct3_q))
                FNC_LB:  ld_data = {{24{shifted[7]}}, shifted[7:0]};
                FNC_LH:  ld_data = {{16{shifted[15]}}, shifted[15:0]};
                FNC_LBU: ld_data = {24'b0, shifted[7:0]};
                FNC_LHU: ld_data = {16'b0, shifted[15:0]};
                default: ld_data = word;
            endcase
        end
    end

endmodule

//--- dmem/dmem.sv
`timescale 1ns/1ns

module dmem #(
    parameter int DMEM_AW = 12
) (
    input                      clk,
    input        [3:0]         wea,
    input        [DMEM_AW-1:0] waddr,
    input        [DMEM_AW-1:0] raddr,
    input        [31:0]        wdata,
    output logic [31:0]        rdata
);

    localparam int DEPTH = 1 << DMEM_AW;

    logic [31:0] mem [DEPTH];

    // Each lane is written on its own enable.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wea[i]) begin
                mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        rdata <= mem[raddr];   // Old data on a same-cycle write.
    end

endmodule

//--- imem/imem.sv
`timescale 1ns/1ns

module imem #(
    parameter int IMEM_AW = 12
) (
    input                      clk,
    input        [3:0]         wea,
    input        [IMEM_AW-1:0] waddr,
    input        [31:0]        wdata,
    input        [IMEM_AW-1:0] fetch_addr,
    output logic [31:0]        instr
);

    localparam int DEPTH = 1 << IMEM_AW;

    logic [31:0] mem [DEPTH];

    // Store port. The write enables arrive already gated by boot space.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wea[i]) begin
                mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // Fetch port.
    always_ff @(posedge clk) begin
        instr <= mem[fetch_addr];
    end

endmodule

//--- mmio/mmio_regs.sv
`timescale 1ns/1ns

module mmio_regs #(
    parameter int LED_W = 6
) (
    input                        clk,
    input                        rst_n,
    input  mem_pkg::io_wr_t      io_wr,
    input        [31:0]          wdata,
    input        [2:0]           raddr_sel,
    output logic [31:0]          rdata,
    output logic [7:0]           uart_tx_data,
    output logic                 uart_tx_valid,
    output logic [LED_W-1:0]     leds,
    output logic                 tx_en,
    output logic [7:0]           tx_duty,
    output logic [31:0]          cycle_count
);
    import mem_pkg::*;

    // ####################################################################
    // Control registers
    // ####################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uart_tx_valid <= 1'b0;
            leds          <= '0;
            tx_en         <= 1'b0;
            tx_duty       <= 8'd0;
        end else begin
            uart_tx_valid <= io_wr.uart_we;   // One pulse per store.
            if (io_wr.leds_we) begin
                leds <= wdata[LED_W-1:0];
            end
            if (io_wr.tx_we && !io_wr.tx_duty_we) begin
                tx_en <= wdata[0];
            end
            if (io_wr.tx_duty_we) begin
                tx_duty <= wdata[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (io_wr.uart_we) begin
            uart_tx_data <= wdata[7:0];
        end
    end

    // Free-running, cleared by a store to the counter word.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_count <= 32'd0;
        end else if (io_wr.counter_reset) begin
            cycle_count <= 32'd0;
        end else begin
            cycle_count <= cycle_count + 32'd1;
        end
    end

    // ####################################################################
    // Read-back
    // ####################################################################

    always_ff @(posedge clk) begin
        case (io_sel_e'(raddr_sel))
            IO_COUNTER: rdata <= cycle_count;
            IO_LEDS:    rdata <= {{(32-LED_W){1'b0}}, leds};
            IO_TX:      rdata <= {24'b0, tx_duty};
            default:    rdata <= 32'd0;
        endcase
    end

endmodule

//--- src/mem_subsys.sv
`timescale 1ns/1ns

module mem_subsys #(
    parameter int DMEM_AW = 12,
    parameter int IMEM_AW = 12,
    parameter int LED_W   = 6
) (
    input                     clk,
    input                     rst_n,
    input  mem_pkg::mem_req_t req,
    input  [31:0]             fetch_addr,
    output [31:0]             ld_data,
    output                    ld_valid,
    output [31:0]             instr,
    output [7:0]              uart_tx_data,
    output                    uart_tx_valid,
    output [LED_W-1:0]        leds,
    output                    tx_en,
    output [7:0]              tx_duty,
    output [31:0]             cycle_count
);
    import mem_pkg::*;

    lane_wr_t    lanes;
    io_wr_t      io_wr;
    logic [31:0] dmem_rdata;
    logic [31:0] io_rdata;

    store_sel u_store_sel (
        .req   (req),
        .lanes (lanes),
        .io_wr (io_wr)
    );

    // Both memories are word addressed.
    dmem #(
        .DMEM_AW (DMEM_AW)
    ) u_dmem (
        .clk   (clk),
        .wea   (lanes.dmem_wea),
        .waddr (req.addr[DMEM_AW+1:2]),
        .raddr (req.addr[DMEM_AW+1:2]),
        .wdata (lanes.data),
        .rdata (dmem_rdata)
    );

    imem #(
        .IMEM_AW (IMEM_AW)
    ) u_imem (
        .clk        (clk),
        .wea        (lanes.imem_wea),
        .waddr      (req.addr[IMEM_AW+1:2]),
        .wdata      (lanes.data),
        .fetch_addr (fetch_addr[IMEM_AW+1:2]),
        .instr      (instr)
    );

    mmio_regs #(
        .LED_W (LED_W)
    ) u_mmio_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .io_wr         (io_wr),
        .wdata         (lanes.data),
        .raddr_sel     (req.addr[IO_SEL_HI:IO_SEL_LO]),
        .rdata         (io_rdata),
        .uart_tx_data  (uart_tx_data),
        .uart_tx_valid (uart_tx_valid),
        .leds          (leds),
        .tx_en         (tx_en),
        .tx_duty       (tx_duty),
        .cycle_count   (cycle_count)
    );

    load_align u_load_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .dmem_rdata (dmem_rdata),
        .io_rdata   (io_rdata),
        .ld_data    (ld_data),
        .ld_valid   (ld_valid)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period.
    end

    // Reset is released shortly after the eighth rising edge.
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #5 rst_n = 1'b1;
    end

endmodule

//--- test/tb_mem_subsys.sv
`timescale 1ns/1ns

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int DMEM_AW       = 12;
    localparam int IMEM_AW       = 12;
    localparam int LED_W         = 6;
    localparam int VALID_TIMEOUT = 8;
    localparam int RESET_TIMEOUT = 20;

    localparam logic [31:0] DMEM_BASE    = 32'h1000_0000;
    localparam logic [31:0] IMEM_BASE    = 32'h2000_0000;
    localparam logic [31:0] UART_ADDR    = 32'h8000_0008;   // Select 1.
    localparam logic [31:0] COUNTER_ADDR = 32'h8000_0018;   // Select 3.
    localparam logic [31:0] LEDS_ADDR    = 32'h8000_0030;   // Select 6.
    localparam logic [31:0] TX_ADDR      = 32'h8000_0038;   // Select 7, duty bit clear.
    localparam logic [31:0] DUTY_ADDR    = 32'h8000_003C;

    logic             clk;
    logic             rst_n;
    mem_req_t         req;
    logic [31:0]      fetch_addr;
    logic [31:0]      ld_data;
    logic             ld_valid;
    logic [31:0]      instr;
    logic [7:0]       uart_tx_data;
    logic             uart_tx_valid;
    logic [LED_W-1:0] leds;
    logic             tx_en;
    logic [7:0]       tx_duty;
    logic [31:0]      cycle_count;

    // Byte models of the first 64 bytes of each memory.
    logic [7:0]       dmem_model [64];
    logic [7:0]       imem_model [64];
    logic [LED_W-1:0] exp_leds;
    logic             exp_tx_en;
    logic [7:0]       exp_duty;
    integer           seed;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_subsys #(
        .DMEM_AW (DMEM_AW),
        .IMEM_AW (IMEM_AW),
        .LED_W   (LED_W)
    ) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .fetch_addr    (fetch_addr),
        .ld_data       (ld_data),
        .ld_valid      (ld_valid),
        .instr         (instr),
        .uart_tx_data  (uart_tx_data),
        .uart_tx_valid (uart_tx_valid),
        .leds          (leds),
        .tx_en         (tx_en),
        .tx_duty       (tx_duty),
        .cycle_count   (cycle_count)
    );

    // ####################################################################
    // Checking and timing helpers
    // ####################################################################

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: time %0t ns, %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic next_sample();
        @(posedge clk);
        #2;   // Inputs change 3 ns later.
    endtask

    task automatic drive(input logic [31:0] addr, input logic [31:0] rs2, input logic we,
                         input opcode_e op, input logic [2:0] f3, input logic pc30);
        req.addr   = addr;
        req.rs2    = rs2;
        req.we     = we;
        req.opcode = op;
        req.funct3 = f3;
        req.pc30   = pc30;
    endtask

    task automatic set_idle();
        drive(32'd0, 32'd0, 1'b0, OPC_OTHER, 3'd0, 1'b0);
    endtask

    // Holds one request for a single cycle and returns just after the edge that takes it.
    task automatic request_cycle(input logic [31:0] addr, input logic [31:0] rs2,
                                 input logic we, input opcode_e op, input logic [2:0] f3,
                                 input logic pc30);
        drive(addr, rs2, we, op, f3, pc30);
        next_sample();
        #3;
        set_idle();
    endtask

    task automatic store(input logic [31:0] addr, input logic [2:0] f3,
                         input logic [31:0] data, input logic pc30);
        request_cycle(addr, data, 1'b1, OPC_STORE, f3, pc30);
    endtask

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            if (cycles >= RESET_TIMEOUT) begin
                $display("timeout: reset was never released");
                abort_run();
            end
            @(posedge clk);
            cycles++;
        end
        #5;
    endtask

    task automatic wait_ld_valid();
        int cycles;
        cycles = 1;
        while (ld_valid !== 1'b1) begin
            if (cycles >= VALID_TIMEOUT) begin
                $display("timeout: ld_valid never rose after a load request");
                abort_run();
            end
            next_sample();
            cycles++;
        end
        check("ld_valid latency in cycles", cycles, 32'd1);
    endtask

    // Leaves the load on req, so a following call issues the next load back to back.
    task automatic load_and_check(input logic [31:0] addr, input logic [2:0] f3,
                                  input logic [31:0] exp);
        drive(addr, 32'd0, 1'b0, OPC_LOAD, f3, 1'b0);
        next_sample();
        wait_ld_valid();
        check("ld_data", ld_data, exp);
        #3;
    endtask

    task automatic end_loads();
        set_idle();
        next_sample();
        check("ld_valid", 32'(ld_valid), 32'd0);
        #3;
    endtask

    task automatic fetch_and_check(input logic [31:0] addr, input logic [31:0] exp);
        fetch_addr = addr;
        next_sample();
        check("instr", instr, exp);
        #3;
    endtask

    // ####################################################################
    // Reference model
    // ####################################################################

    function automatic logic [31:0] dmem_addr(input int w, input int o);
        return DMEM_BASE + 32'(4 * w + o);
    endfunction

    // A halfword store uses addr[1] only, a word store ignores both low bits.
    function automatic void model_write(input bit to_imem, input logic [31:0] addr,
                                        input logic [2:0] f3, input logic [31:0] data);
        logic [5:0] base;
        int         nbytes;
        base = addr[5:0];
        case (store_funct_e'(f3))
            FNC_SB: begin
                nbytes = 1;
            end
            FNC_SH: begin
                nbytes  = 2;
                base[0] = 1'b0;
            end
            FNC_SW: begin
                nbytes    = 4;
                base[1:0] = 2'b00;
            end
            default: begin
                nbytes = 0;
            end
        endcase
        for (int i = 0; i < nbytes; i++) begin
            if (to_imem) begin
                imem_model[base + 6'(i)] = data[8*i +: 8];
            end else begin
                dmem_model[base + 6'(i)] = data[8*i +: 8];
            end
        end
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input logic [2:0] f3);
        logic [5:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        a = addr[5:0];
        b = dmem_model[a];
        h = {dmem_model[{a[5:1], 1'b1}], dmem_model[{a[5:1], 1'b0}]};
        w = {dmem_model[{a[5:2], 2'd3}], dmem_model[{a[5:2], 2'd2}],
             dmem_model[{a[5:2], 2'd1}], dmem_model[{a[5:2], 2'd0}]};
        case (load_funct_e'(f3))
            FNC_LB:  return {{24{b[7]}}, b};
            FNC_LH:  return {{16{h[15]}}, h};
            FNC_LBU: return {24'd0, b};
            FNC_LHU: return {16'd0, h};
            default: return w;
        endcase
    endfunction

    function automatic logic [31:0] expected_fetch(input logic [31:0] addr);
        logic [5:0] a;
        a = addr[5:0];
        return {imem_model[{a[5:2], 2'd3}], imem_model[{a[5:2], 2'd2}],
                imem_model[{a[5:2], 2'd1}], imem_model[{a[5:2], 2'd0}]};
    endfunction

    task automatic load_from_model(input logic [31:0] addr, input logic [2:0] f3);
        load_and_check(addr, f3, expected_load(addr, f3));
    endtask

    // ####################################################################
    // Directed tests
    // ####################################################################

    task automatic lane_access();
        logic [31:0] data;
        for (int w = 0; w < 4; w++) begin
            data = $random(seed);
            store(dmem_addr(w, w), FNC_SW, data, 1'b0);   // Low address bits are ignored.
            model_write(1'b0, dmem_addr(w, w), FNC_SW, data);
        end
        for (int o = 0; o < 4; o++) begin
            data = $random(seed);
            store(dmem_addr(0, o), FNC_SB, data, 1'b0);
            model_write(1'b0, dmem_addr(0, o), FNC_SB, data);
            data = $random(seed);
            store(dmem_addr(1, o), FNC_SH, data, 1'b0);
            model_write(1'b0, dmem_addr(1, o), FNC_SH, data);
        end
        for (int w = 0; w < 4; w++) begin
            for (int o = 0; o < 4; o++) begin
                load_from_model(dmem_addr(w, o), FNC_LB);
                load_from_model(dmem_addr(w, o), FNC_LBU);
                if (o % 2 == 0) begin
                    load_from_model(dmem_addr(w, o), FNC_LH);
                    load_from_model(dmem_addr(w, o), FNC_LHU);
                end
            end
            load_from_model(dmem_addr(w, 0), FNC_LW);
            end_loads();
        end
    endtask

    task automatic ignored_stores();
        logic [31:0] data;
        data = $random(seed);
        store(dmem_addr(5, 0), FNC_SW, data, 1'b0);
        model_write(1'b0, dmem_addr(5, 0), FNC_SW, data);
        request_cycle(dmem_addr(5, 0), ~data, 1'b0, OPC_STORE, FNC_SW, 1'b0);
        request_cycle(dmem_addr(5, 0), ~data, 1'b1, OPC_OTHER, FNC_SW, 1'b0);
        request_cycle(dmem_addr(5, 0), ~data, 1'b1, OPC_STORE, 3'b011, 1'b0);
        request_cycle(dmem_addr(5, 0), ~data, 1'b1, OPC_STORE, 3'b111, 1'b0);
        load_from_model(dmem_addr(5, 0), FNC_LW);
        end_loads();
    endtask

    task automatic boot_writes();
        logic [31:0] data;
        logic [31:0] boot_word;
        data = $random(seed);
        store(IMEM_BASE + 32'd8, FNC_SW, data, 1'b1);
        model_write(1'b1, IMEM_BASE + 32'd8, FNC_SW, data);
        data = $random(seed);
        store(IMEM_BASE + 32'd10, FNC_SB, data, 1'b1);
        model_write(1'b1, IMEM_BASE + 32'd10, FNC_SB, data);
        boot_word = expected_fetch(IMEM_BASE + 32'd8);
        fetch_and_check(IMEM_BASE + 32'd8, boot_word);
        // Outside boot space the same store must be dropped.
        store(IMEM_BASE + 32'd8, FNC_SW, ~boot_word, 1'b0);
        fetch_and_check(IMEM_BASE + 32'd8, boot_word);
    endtask

    task automatic uart_strobe();
        logic [31:0] data;
        data = $random(seed);
        store(UART_ADDR, FNC_SB, data, 1'b0);
        check("uart_tx_valid", 32'(uart_tx_valid), 32'd1);
        check("uart_tx_data", 32'(uart_tx_data), {24'd0, data[7:0]});
        next_sample();
        check("uart_tx_valid", 32'(uart_tx_valid), 32'd0);
        #3;
        store(UART_ADDR + 32'd1, FNC_SB, ~data, 1'b0);
        check("uart_tx_valid", 32'(uart_tx_valid), 32'd0);
        check("uart_tx_data", 32'(uart_tx_data), {24'd0, data[7:0]});
    endtask

    // The LED word sits inside the TX window, so one store can hit both.
    task automatic io_write(input logic [31:0] addr, input logic [31:0] data);
        store(addr, FNC_SW, data, 1'b0);
        if (addr[5:3] == 3'd6) begin
            exp_leds = data[LED_W-1:0];
        end
        if (addr[5:4] == 2'd3) begin
            if (addr[2]) begin
                exp_duty = data[7:0];
            end else begin
                exp_tx_en = data[0];
            end
        end
        check("leds", 32'(leds), 32'(exp_leds));
        check("tx_en", 32'(tx_en), 32'(exp_tx_en));
        check("tx_duty", 32'(tx_duty), 32'(exp_duty));
    endtask

    task automatic io_registers();
        io_write(LEDS_ADDR, $random(seed));
        io_write(TX_ADDR, 32'd1);
        io_write(TX_ADDR, 32'd0);
        io_write(DUTY_ADDR, $random(seed));
        io_write(LEDS_ADDR + 32'd4, $random(seed));
        io_write(TX_ADDR, 32'd1);
        load_and_check(LEDS_ADDR, FNC_LW, 32'(exp_leds));
        load_and_check(TX_ADDR, FNC_LW, 32'(exp_duty));
        load_and_check(DUTY_ADDR, FNC_LB, 32'(exp_duty));   // I/O loads return the word.
        load_and_check(UART_ADDR, FNC_LW, 32'd0);
        end_loads();
    endtask

    task automatic counter_timing();
        store(COUNTER_ADDR, FNC_SW, 32'hffff_ffff, 1'b0);
        check("cycle_count", cycle_count, 32'd0);
        for (int i = 1; i <= 5; i++) begin
            next_sample();
            check("cycle_count", cycle_count, 32'(i));
            #3;
        end
        for (int n = 0; n <= 6; n += 3) begin
            store(COUNTER_ADDR, FNC_SW, 32'hffff_ffff, 1'b0);
            check("cycle_count", cycle_count, 32'd0);
            for (int i = 0; i < n; i++) begin
                next_sample();
                #3;
            end
            check("cycle_count", cycle_count, 32'(n));
            load_and_check(COUNTER_ADDR, FNC_LW, 32'(n));
            end_loads();
        end
    endtask

    initial begin
        seed       = 32'h7455;
        fetch_addr = 32'd0;
        exp_leds   = '0;
        exp_tx_en  = 1'b0;
        exp_duty   = 8'd0;
        set_idle();
        wait_for_reset();
        check("ld_valid", 32'(ld_valid), 32'd0);
        check("uart_tx_valid", 32'(uart_tx_valid), 32'd0);
        check("leds", 32'(leds), 32'd0);
        check("tx_en", 32'(tx_en), 32'd0);
        check("tx_duty", 32'(tx_duty), 32'd0);
        check("cycle_count", cycle_count, 32'd1);   // One edge since release.
        lane_access();
        ignored_stores();
        boot_writes();
        uart_strobe();
        io_registers();
        counter_timing();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- src.f
common/mem_pkg.sv
src/store_sel.sv
src/load_align.sv
dmem/dmem.sv
imem/imem.sv
mmio/mmio_regs.sv
src/mem_subsys.sv
test/tb_clock.sv
test/tb_mem_subsys.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the memory stage testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_mem_subsys \
    -f src.f \
    -o tb_mem_subsys

# The log decides the result, so a failing run must not stop the script here.
./obj_dir/tb_mem_subsys > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qF "** PASS **" "$LOG"; then
    echo "Simulation passed."
else
    echo "Simulation failed, see $LOG." >&2
    exit 1
fi
